// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_core
FILELIST   := sim.f
BUILD_DIR  := obj_dir
COMMON     := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
source/core_pkg.sv
source/fetch_stage.sv
source/decoder.sv
source/reg_file.sv
source/forward_unit.sv
source/alu.sv
source/core_datapath.sv
verif/tb_core.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e         op_i,
  input  logic [core_pkg::XLEN-1:0] a_i,
  input  logic [core_pkg::XLEN-1:0] b_i,
  output logic [core_pkg::XLEN-1:0] result_o
);
  import core_pkg::*;

  logic [SHAMT_W-1:0] shamt;

  // only the low bits count for shifts
  assign shamt = b_i[SHAMT_W-1:0];

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SLT: begin
        result_o = XLEN'($signed(a_i) < $signed(b_i));
      end
      ALU_SLTU: begin
        result_o = XLEN'(a_i < b_i);
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = $unsigned($signed(a_i) >>> shamt);
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== source/core_datapath.sv ====
`timescale 1ns/1ps

module core_datapath (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic                            run_i,
  input  logic [core_pkg::XLEN-1:0]       inst_i,
  output logic [core_pkg::XLEN-1:0]       pc_o,
  output logic                            wb_valid_o,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]       wb_data_o
);
  import core_pkg::*;

  if_id_t   if_id;
  id_exe_t  id_exe_d, id_exe_q;
  exe_mem_t exe_mem_d, exe_mem_q;
  mem_wb_t  mem_wb_d, mem_wb_q;

  ctrl_t                 ctrl_id;
  logic [XLEN-1:0]       imm_id;
  logic [REG_ADDR_W-1:0] rs1_id, rs2_id, rd_id;
  logic [XLEN-1:0]       rdata1_id, rdata2_id;

  fwd_sel_e        fwd1_exe, fwd2_exe;
  logic [XLEN-1:0] rs1_val_exe, rs2_val_exe;
  logic [XLEN-1:0] alu_a_exe, alu_b_exe;
  logic [XLEN-1:0] alu_result_exe;
  logic [XLEN-1:0] result_mem;

  fetch_stage fetch_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .run_i    (run_i),
    .inst_i   (inst_i),
    .pc_o     (pc_o),
    .if_id_o  (if_id)
  );

  // ====================
  // decode
  // ====================

  decoder decoder_inst (
    .inst_i (if_id.inst),
    .ctrl_o (ctrl_id),
    .imm_o  (imm_id),
    .rs1_o  (rs1_id),
    .rs2_o  (rs2_id),
    .rd_o   (rd_id)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .raddr1_i (rs1_id),
    .raddr2_i (rs2_id),
    .wr_i     (mem_wb_q),
    .rdata1_o (rdata1_id),
    .rdata2_o (rdata2_id)
  );

  assign id_exe_d = '{
    pc:     if_id.pc,
    rs1:    rs1_id,
    rs2:    rs2_id,
    rd:     rd_id,
    rdata1: rdata1_id,
    rdata2: rdata2_id,
    imm:    imm_id,
    ctrl:   ctrl_id
  };

  // ====================
  // execute
  // ====================

  forward_unit forward_inst (
    .rs1_i     (id_exe_q.rs1),
    .rs2_i     (id_exe_q.rs2),
    .exe_mem_i (exe_mem_q),
    .mem_wb_i  (mem_wb_q),
    .fwd1_o    (fwd1_exe),
    .fwd2_o    (fwd2_exe)
  );

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val);
    logic [XLEN-1:0] val;
    case (sel)
      FWD_MEM: val = result_mem;
      FWD_WB:  val = mem_wb_q.result;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  always_comb begin
    rs1_val_exe = fwd_mux(fwd1_exe, id_exe_q.rdata1);
    rs2_val_exe = fwd_mux(fwd2_exe, id_exe_q.rdata2);
  end

  // auipc adds to its own pc
  assign alu_a_exe = id_exe_q.ctrl.auipc ? id_exe_q.pc : rs1_val_exe;
  assign alu_b_exe = id_exe_q.ctrl.alu_src ? id_exe_q.imm : rs2_val_exe;

  alu alu_inst (
    .op_i     (id_exe_q.ctrl.alu_op),
    .a_i      (alu_a_exe),
    .b_i      (alu_b_exe),
    .result_o (alu_result_exe)
  );

  assign exe_mem_d = '{
    rd:         id_exe_q.rd,
    reg_write:  id_exe_q.ctrl.reg_write,
    lui:        id_exe_q.ctrl.lui,
    alu_result: alu_result_exe,
    imm:        id_exe_q.imm
  };

  // ====================
  // memory and writeback
  // ====================

  // lui bypasses the alu
  assign result_mem = exe_mem_q.lui ? exe_mem_q.imm : exe_mem_q.alu_result;

  assign mem_wb_d = '{
    rd:        exe_mem_q.rd,
    reg_write: exe_mem_q.reg_write,
    result:    result_mem
  };

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_exe_q  <= '0;
      exe_mem_q <= '0;
      mem_wb_q  <= '0;
    end else begin
      id_exe_q  <= id_exe_d;
      exe_mem_q <= exe_mem_d;
      mem_wb_q  <= mem_wb_d;
    end
  end

  assign wb_valid_o = mem_wb_q.reg_write;
  assign wb_rd_o    = mem_wb_q.rd;
  assign wb_data_o  = mem_wb_q.result;

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

  // ====================
  // widths and constants
  // ====================

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;
  localparam int SHAMT_W    = $clog2(XLEN);

  localparam logic [XLEN-1:0] RESET_PC = '0;
  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // ====================
  // encodings
  // ====================

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // follows {funct7[5], funct3} where that is unambiguous
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // execute operand source
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

  // ====================
  // pipeline registers
  // ====================

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic    reg_write;
    logic    alu_src;
    logic    auipc;
    logic    lui;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
  } id_exe_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  lui;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       imm;
  } exe_mem_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic [XLEN-1:0]       result;
  } mem_wb_t;

endpackage

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder (
  input  logic [core_pkg::XLEN-1:0]       inst_i,
  output core_pkg::ctrl_t                 ctrl_o,
  output logic [core_pkg::XLEN-1:0]       imm_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rd_o
);
  import core_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  alu_op_e         alu_op;

  assign opcode   = opcode_e'(inst_i[6:0]);
  assign funct3   = inst_i[14:12];
  assign funct7_5 = inst_i[30];
  assign rd_o     = inst_i[11:7];
  assign rs1_o    = inst_i[19:15];
  assign rs2_o    = inst_i[24:20];

  assign imm_i_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};

  // funct7 bit 5 picks SUB only for register ops, SRA/SRAI for both
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == OP && funct7_5) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  // ====================
  // control fields
  // ====================

  always_comb begin
    ctrl_o = '0;
    imm_o  = '0;
    case (opcode)
      OP: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = alu_op;
      end
      OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_src   = 1'b1;
        ctrl_o.alu_op    = alu_op;
        imm_o            = imm_i_type;
      end
      LUI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_src   = 1'b1;
        ctrl_o.lui       = 1'b1;
        imm_o            = imm_u_type;
      end
      AUIPC: begin
        // pc + imm through the adder
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_src   = 1'b1;
        ctrl_o.auipc     = 1'b1;
        imm_o            = imm_u_type;
      end
      default: begin
        ctrl_o = '0;
      end
    endcase
    // x0 is never a destination
    if (rd_o == '0) begin
      ctrl_o.reg_write = 1'b0;
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      run_i,
  input  logic [core_pkg::XLEN-1:0] inst_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output core_pkg::if_id_t          if_id_o
);
  import core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_plus_4;

  assign pc_plus_4 = pc_q + XLEN'(4);
  assign pc_o      = pc_q;

  // pc holds while stalled
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else if (run_i) begin
      pc_q <= pc_plus_4;
    end
  end

  // ====================
  // IF-ID register
  // ====================

  // a stall pushes a nop bubble into decode
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      if_id_o <= '{pc: RESET_PC, inst: NOP_INST};
    end else if (run_i) begin
      if_id_o <= '{pc: pc_q, inst: inst_i};
    end else begin
      if_id_o <= '{pc: pc_q, inst: NOP_INST};
    end
  end

endmodule

// ==== source/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
  input  core_pkg::exe_mem_t              exe_mem_i,
  input  core_pkg::mem_wb_t               mem_wb_i,
  output core_pkg::fwd_sel_e              fwd1_o,
  output core_pkg::fwd_sel_e              fwd2_o
);
  import core_pkg::*;

  // the younger producer in MEM wins over WB
  function automatic fwd_sel_e pick_source(input logic [REG_ADDR_W-1:0] rs);
    fwd_sel_e sel;
    if (exe_mem_i.reg_write && exe_mem_i.rd == rs) begin
      sel = FWD_MEM;
    end else if (mem_wb_i.reg_write && mem_wb_i.rd == rs) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  // reg_write is already low for rd == x0
  always_comb begin
    fwd1_o = pick_source(rs1_i);
    fwd2_o = pick_source(rs2_i);
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
  input  core_pkg::mem_wb_t               wr_i,
  output logic [core_pkg::XLEN-1:0]       rdata1_o,
  output logic [core_pkg::XLEN-1:0]       rdata2_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // x0 reads zero, a same-cycle write is bypassed
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_i.reg_write && wr_i.rd == addr) begin
      data = wr_i.result;
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '{default: '0};
    end else if (wr_i.reg_write) begin
      regs_q[wr_i.rd] <= wr_i.result;
    end
  end

endmodule

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic [31:0]           due;
  } wb_exp_t;

  localparam int PROG_WORDS = 256;

  logic                  clk;
  logic                  arst_n_i;
  logic                  run_i;
  logic [XLEN-1:0]       inst_i;
  logic [XLEN-1:0]       pc_o;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]       wb_data_o;

  logic [31:0]     rng_state;
  logic [XLEN-1:0] prog [PROG_WORDS];
  logic [XLEN-1:0] regs [NUM_REGS];
  wb_exp_t         exp_q [$];
  logic [31:0]     cycle;
  logic [XLEN-1:0] model_pc;
  // inputs seen by the DUT at the next edge
  logic            run_prev;
  logic [XLEN-1:0] inst_prev;
  logic [XLEN-1:0] pc_prev;

  core_datapath DUT (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .run_i      (run_i),
    .inst_i     (inst_i),
    .pc_o       (pc_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================
  // stimulus generation
  // ====================

  function logic [31:0] rand_word();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ {16'h0000, rng_state[31:16]};
  endfunction

  // registers limited to x0..x7 for dense dependencies
  function automatic logic [XLEN-1:0] make_inst();
    logic [31:0]     r;
    logic [31:0]     u;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [11:0]     imm12;
    logic [6:0]      bad_opc;
    logic [XLEN-1:0] inst;
    r     = rand_word();
    u     = rand_word();
    rd    = {2'b00, r[2:0]};
    rs1   = {2'b00, r[5:3]};
    rs2   = {2'b00, r[8:6]};
    f3    = r[11:9];
    // alternate encoding only for sub and sra
    f7    = (r[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
    imm12 = (f3 == 3'd1 || f3 == 3'd5) ? {f7, u[4:0]} : u[11:0];
    case (u[13:12])
      2'd0:    bad_opc = 7'b0000011;
      2'd1:    bad_opc = 7'b0100011;
      2'd2:    bad_opc = 7'b1100011;
      default: bad_opc = 7'b1101111;
    endcase
    if (r[16:13] < 4'd5) begin
      inst = {f7, rs2, rs1, f3, rd, 7'b0110011};
    end else if (r[16:13] < 4'd10) begin
      inst = {imm12, rs1, f3, rd, 7'b0010011};
    end else if (r[16:13] < 4'd12) begin
      inst = {u[31:12], rd, 7'b0110111};
    end else if (r[16:13] < 4'd14) begin
      inst = {u[31:12], rd, 7'b0010111};
    end else begin
      inst = {u[31:7], bad_opc};
    end
    return inst;
  endfunction

  // past the program end the core sees nops
  function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] w;
    if (pc[31:10] == 22'd0) begin
      w = prog[pc[9:2]];
    end else begin
      w = NOP_INST;
    end
    return w;
  endfunction

  // ====================
  // reference model
  // ====================

  function automatic logic [XLEN-1:0] compute_result(input logic [2:0] f3, input logic alt,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] fill;
    // sign bits shifted in by sra
    fill = {XLEN{a[31]}} & ~({XLEN{1'b1}} >> b[4:0]);
    case (f3)
      3'd0:    res = alt ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'd3:    res = {31'd0, a < b};
      3'd4:    res = a ^ b;
      3'd5:    res = alt ? (a >> b[4:0]) | fill : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  task automatic execute_ref(input logic [XLEN-1:0] inst, input logic [XLEN-1:0] pc);
    logic [4:0]      rd;
    logic [2:0]      f3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] res;
    logic            wr;
    wb_exp_t         item;
    rd    = inst[11:7];
    f3    = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'h000};
    wr    = 1'b1;
    case (inst[6:0])
      7'b0110011: res = compute_result(f3, inst[30], regs[inst[19:15]], regs[inst[24:20]]);
      7'b0010011: res = compute_result(f3, f3 == 3'd5 && inst[30], regs[inst[19:15]], imm_i);
      7'b0110111: res = imm_u;
      7'b0010111: res = pc + imm_u;
      default: begin
        res = '0;
        wr  = 1'b0;
      end
    endcase
    if (wr && rd != 5'd0) begin
      regs[rd]  = res;
      item.rd   = rd;
      item.data = res;
      item.due  = cycle + 32'd3;
      exp_q.push_back(item);
    end
  endtask

  // ====================
  // checking
  // ====================

  task automatic fail_on_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_on_timeout(input string msg);
    $display("timeout after %0d cycles: %s", cycle, msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on a timeout");
  endtask

  task automatic check_outputs();
    wb_exp_t head;
    assert (pc_o == model_pc)
      else fail_on_mismatch($sformatf("pc_o %h, expected %h", pc_o, model_pc));
    if (wb_valid_o) begin
      assert (exp_q.size() != 0)
        else fail_on_mismatch($sformatf("unexpected write-back to x%0d", wb_rd_o));
      head = exp_q.pop_front();
      assert (wb_rd_o == head.rd && wb_data_o == head.data)
        else fail_on_mismatch($sformatf("write-back x%0d=%h, expected x%0d=%h",
                                        wb_rd_o, wb_data_o, head.rd, head.data));
      assert (cycle == head.due)
        else fail_on_mismatch($sformatf("write-back at edge %0d, expected at edge %0d",
                                        cycle, head.due));
    end else if (exp_q.size() != 0) begin
      head = exp_q[0];
      assert (head.due != cycle)
        else fail_on_mismatch($sformatf("missing write-back to x%0d", head.rd));
    end
  endtask

  task automatic drive_inputs(input logic run);
    run_i     = run;
    inst_i    = fetch_word(pc_o);
    run_prev  = run;
    inst_prev = inst_i;
    pc_prev   = pc_o;
  endtask

  // one edge, then model update, checks and new inputs 1 ns later
  task automatic advance_cycle(input logic run);
    @(posedge clk);
    cycle = cycle + 32'd1;
    #1;
    if (run_prev) begin
      execute_ref(inst_prev, pc_prev);
      model_pc = model_pc + 32'd4;
    end
    check_outputs();
    drive_inputs(run);
  endtask

  initial begin
    int          i;
    logic [31:0] r;
    logic [31:0] waited;
    arst_n_i  = 1'b0;
    run_i     = 1'b0;
    inst_i    = NOP_INST;
    rng_state = 32'h860;
    cycle     = '0;
    model_pc  = RESET_PC;
    run_prev  = 1'b0;
    inst_prev = NOP_INST;
    pc_prev   = RESET_PC;
    for (i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < PROG_WORDS; i++) begin
      prog[i] = make_inst();
    end

    for (i = 0; i < 16; i++) begin
      advance_cycle(1'b0);
    end
    arst_n_i = 1'b1;
    // idle after reset, pc must hold
    for (i = 0; i < 3; i++) begin
      advance_cycle(1'b0);
    end

    // stall about one cycle in five
    waited = '0;
    while (model_pc[31:10] == 22'd0) begin
      r = rand_word();
      advance_cycle((r % 32'd5) != 32'd0);
      waited = waited + 32'd1;
      if (waited > 32'd2000) begin
        abort_on_timeout("the program was not fetched to its end");
      end
    end

    waited = '0;
    while (exp_q.size() != 0) begin
      advance_cycle(1'b1);
      waited = waited + 32'd1;
      if (waited > 32'd16) begin
        abort_on_timeout("expected write-backs never arrived");
      end
    end
    // no stray strobes once drained
    for (i = 0; i < 6; i++) begin
      advance_cycle(1'b1);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule
